//--- source/ccc_pkg.sv
// CCC handler package: command codes, field types, byte counts and sequencer states
package ccc_pkg;

  // Field types
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;
  typedef logic [15:0] len_t;
  typedef logic [47:0] pid_t;

  // Broadcast command codes
  localparam byte_t CccEnecB     = 8'h00;
  localparam byte_t CccDisecB    = 8'h01;
  localparam byte_t CccRstdaa    = 8'h06;
  localparam byte_t CccSetmwlB   = 8'h09;
  localparam byte_t CccSetmrlB   = 8'h0A;
  localparam byte_t CccEndxferB  = 8'h12;
  localparam byte_t CccSetaasa   = 8'h29;
  localparam byte_t CccRstactB   = 8'h2A;

  // Direct command codes
  localparam byte_t CccEnecD     = 8'h80;
  localparam byte_t CccDisecD    = 8'h81;
  localparam byte_t CccSetdasa   = 8'h87;
  localparam byte_t CccSetmwlD   = 8'h89;
  localparam byte_t CccSetmrlD   = 8'h8A;
  localparam byte_t CccGetmwl    = 8'h8B;
  localparam byte_t CccGetmrl    = 8'h8C;
  localparam byte_t CccGetpid    = 8'h8D;
  localparam byte_t CccGetbcr    = 8'h8E;
  localparam byte_t CccGetdcr    = 8'h8F;
  localparam byte_t CccGetstatus = 8'h90;
  localparam byte_t CccEndxferD  = 8'h92;
  localparam byte_t CccRstactD   = 8'h9A;

  // Code bit set for every direct CCC
  localparam int DirectBit = 7;

  // I3C broadcast address
  localparam addr_t RsvdAddr = 7'h7E;

  // Longest GET response (GETPID)
  localparam int MaxGetBytes = 6;

  // GETMRL third byte, max IBI payload
  localparam byte_t IbiLimitByte = 8'hFF;

  // ENEC/DISEC event bit positions
  localparam int EnecIbiBit = 0;
  localparam int EnecCrrBit = 1;
  localparam int EnecHjBit  = 3;

  // Sequencer states
  typedef enum logic [4:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxDefByte,
    RxDefByteTbit,
    RxByte,
    RxDirectDefByteTbit,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    WaitStop,
    DoneCcc
  } ccc_state_e;

endpackage

//--- source/ccc_seq_fsm.sv
// CCC sequencer FSM: bus requests, address capture and match, received byte and count
`timescale 1ns/10ps

module ccc_seq_fsm import ccc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  byte_t ccc_i,
  input  logic  ccc_valid_i,
  input  logic  bus_rstart_det_i,
  input  logic  bus_stop_det_i,
  input  logic  bus_rx_done_i,
  input  byte_t bus_rx_data_i,
  input  logic  bus_tx_done_i,
  input  addr_t target_sta_address_i,
  input  logic  target_sta_address_valid_i,
  input  addr_t target_dyn_address_i,
  input  logic  target_dyn_address_valid_i,
  input  byte_t tx_byte_i,
  input  logic  tx_last_i,
  output logic  done_o,
  output logic  bus_rx_req_bit_o,
  output logic  bus_rx_req_byte_o,
  output logic  bus_tx_req_bit_o,
  output logic  bus_tx_req_byte_o,
  output byte_t bus_tx_req_value_o,
  output logic  bus_tx_sel_od_pp_o,
  output byte_t command_code_o,
  output byte_t rx_byte_o,
  output byte_t rx_count_o,
  output logic  data_done_strobe_o,
  output logic  bcast_tbit_strobe_o,
  output logic  addr_phase_ok_o,
  output logic  tx_load_o,
  output logic  tx_advance_o
);

  ccc_state_e state_q, state_d;
  byte_t      command_code_q;
  addr_t      cmd_addr_q;
  logic       cmd_rnw_q;
  byte_t      rx_byte_q;
  byte_t      rx_count_q;
  logic       addr_ok_q;
  logic       is_direct;
  logic       has_def_byte;
  addr_t      own_addr;
  logic       own_addr_valid;
  logic       addr_match;
  logic       addr_rsvd;
  logic       rx_addr_match;

  // Latch code when primary FSM hands over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      command_code_q <= '0;
    end else if (ccc_valid_i) begin
      command_code_q <= ccc_i;
    end
  end

  assign is_direct    = command_code_q[DirectBit];
  assign has_def_byte = command_code_q inside {CccEndxferB, CccRstactB,
                                               CccEndxferD, CccRstactD};

  // Dynamic address wins once assigned
  assign own_addr       = target_dyn_address_valid_i ? target_dyn_address_i
                                                     : target_sta_address_i;
  assign own_addr_valid = target_dyn_address_valid_i | target_sta_address_valid_i;
  assign addr_match     = own_addr_valid && (cmd_addr_q == own_addr);
  assign addr_rsvd      = (cmd_addr_q == RsvdAddr);
  // Same check on the byte still on the receiver
  assign rx_addr_match  = own_addr_valid && (bus_rx_data_i[7:1] == own_addr);

  // Address byte: 7-bit address plus RnW
  always_ff @(posedge clk_i) begin
    if (state_q == RxDirectAddr && bus_rx_done_i) begin
      cmd_addr_q <= bus_rx_data_i[7:1];
      cmd_rnw_q  <= bus_rx_data_i[0];
    end
  end

  // Match flag, held until next address or next CCC
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ok_q <= 1'b0;
    end else if (ccc_valid_i) begin
      addr_ok_q <= 1'b0;
    end else if (state_q == RxDirectAddr && bus_rx_done_i) begin
      addr_ok_q <= rx_addr_match;
    end
  end

  // Last data byte seen
  always_ff @(posedge clk_i) begin
    if (state_q == RxData && bus_rx_done_i) begin
      rx_byte_q <= bus_rx_data_i;
    end
  end

  // Bytes since CCC start or last address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_count_q <= '0;
    end else if (state_q == WaitCcc && ccc_valid_i) begin
      rx_count_q <= '0;
    end else if (state_q == RxDirectAddr && bus_rx_done_i) begin
      rx_count_q <= '0;
    end else if (state_q == RxDataTbit && bus_rx_done_i) begin
      rx_count_q <= rx_count_q + 8'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:    state_d = WaitCcc;
      WaitCcc: if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        if (bus_rx_done_i) begin
          if (has_def_byte) state_d = RxDefByte;
          else if (is_direct) state_d = RxByte;
          else state_d = RxData;
        end
      end
      RxDefByte: if (bus_rx_done_i) state_d = RxDefByteTbit;
      RxDefByteTbit: begin
        if (bus_rx_done_i) state_d = is_direct ? RxByte : RxData;
      end
      // Direct: skip bytes until Sr opens the address phase
      RxByte: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDirectDefByteTbit;
      end
      RxDirectDefByteTbit: if (bus_rx_done_i) state_d = RxByte;
      RxDirectAddr: if (bus_rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (bus_tx_done_i) begin
          if (addr_rsvd) state_d = WaitStop;
          else if (addr_match && cmd_rnw_q) state_d = TxData;
          else if (addr_match) state_d = RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: if (bus_rx_done_i) state_d = RxData;
      TxData: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (bus_tx_done_i) state_d = tx_last_i ? WaitBusCond : TxData;
      end
      WaitBusCond: if (bus_rstart_det_i) state_d = RxDirectAddr;
      // Only STOP leaves, via the override below
      WaitStop: state_d = WaitStop;
      DoneCcc:  state_d = Idle;
      default:  state_d = Idle;
    endcase
  end

  // STOP ends the CCC from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_stop_det_i) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  // Requests held as levels per state
  always_comb begin
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_value_o = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    unique case (state_q)
      RxTbit, RxDefByteTbit, RxDirectDefByteTbit, RxDataTbit: bus_rx_req_bit_o = 1'b1;
      RxDefByte, RxDirectAddr: bus_rx_req_byte_o = 1'b1;
      // Drop byte request once Sr shows up
      RxByte, RxData: bus_rx_req_byte_o = ~bus_rstart_det_i;
      TxAddrAck: begin
        // ACK is low, open drain
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~addr_match};
      end
      TxData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = tx_byte_i;
        bus_tx_sel_od_pp_o = 1'b1;
      end
      TxDataTbit: begin
        // T-bit low ends the read
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~tx_last_i};
        bus_tx_sel_od_pp_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign done_o          = (state_q == DoneCcc);
  assign command_code_o  = command_code_q;
  assign rx_byte_o       = rx_byte_q;
  assign rx_count_o      = rx_count_q;
  assign addr_phase_ok_o = addr_ok_q;

  // Direct writes only count after our own address
  assign data_done_strobe_o  = (state_q == RxDataTbit) && bus_rx_done_i &&
                               (~is_direct || addr_ok_q);
  assign bcast_tbit_strobe_o = (state_q == RxTbit) && bus_rx_done_i;
  assign tx_load_o           = (state_q == TxAddrAck) && bus_tx_done_i;
  assign tx_advance_o        = (state_q == TxData) && bus_tx_done_i;

endmodule

//--- source/ccc_get_tx.sv
// GET response countdown and byte selection from configuration inputs
`timescale 1ns/10ps

module ccc_get_tx import ccc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  byte_t command_code_i,
  input  logic  load_i,
  input  logic  advance_i,
  input  byte_t get_bcr_i,
  input  byte_t get_dcr_i,
  input  len_t  get_mwl_i,
  input  len_t  get_mrl_i,
  input  pid_t  get_pid_i,
  input  len_t  get_status_fmt1_i,
  output byte_t tx_byte_o,
  output logic  tx_last_o
);

  // Response right-aligned, first byte highest
  logic [8*MaxGetBytes-1:0] resp;
  byte_t                    resp_len;
  byte_t                    remain_q;

  always_comb begin
    resp     = '0;
    resp_len = 8'd0;
    unique case (command_code_i)
      CccGetbcr: begin
        resp[7:0] = get_bcr_i;
        resp_len  = 8'd1;
      end
      CccGetdcr: begin
        resp[7:0] = get_dcr_i;
        resp_len  = 8'd1;
      end
      CccGetmwl: begin
        resp[15:0] = get_mwl_i;
        resp_len   = 8'd2;
      end
      // MRL then IBI payload limit
      CccGetmrl: begin
        resp[23:0] = {get_mrl_i, IbiLimitByte};
        resp_len   = 8'd3;
      end
      CccGetpid: begin
        resp     = get_pid_i;
        resp_len = 8'd6;
      end
      // Format 1 only
      CccGetstatus: begin
        resp[15:0] = get_status_fmt1_i;
        resp_len   = 8'd2;
      end
      default: ;
    endcase
  end

  // Bytes still to send
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (load_i) begin
      remain_q <= resp_len;
    end else if (advance_i && remain_q != 8'd0) begin
      remain_q <= remain_q - 8'd1;
    end
  end

  // Count N picks byte N-1 of the response
  always_comb begin
    if (remain_q == 8'd0 || remain_q > MaxGetBytes) begin
      tx_byte_o = '0;
    end else begin
      tx_byte_o = resp[(remain_q - 8'd1) * 8 +: 8];
    end
  end

  assign tx_last_o = (remain_q == 8'd0);

endmodule

//--- source/ccc_set_regs.sv
// SET capture registers: ENEC/DISEC flags, MWL/MRL, dynamic address and RSTDAA strobes
`timescale 1ns/10ps

module ccc_set_regs import ccc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  byte_t command_code_i,
  input  byte_t rx_byte_i,
  input  byte_t rx_count_i,
  input  logic  data_done_strobe_i,
  input  logic  bcast_tbit_strobe_i,
  input  addr_t target_sta_address_i,
  output logic  enec_ibi_o,
  output logic  enec_crr_o,
  output logic  enec_hj_o,
  output logic  disec_ibi_o,
  output logic  disec_crr_o,
  output logic  disec_hj_o,
  output logic  set_mwl_o,
  output len_t  mwl_o,
  output logic  set_mrl_o,
  output len_t  mrl_o,
  output addr_t set_dasa_o,
  output logic  set_dasa_valid_o,
  output logic  rstdaa_o
);

  logic is_enec;
  logic is_disec;
  logic is_mwl;
  logic is_mrl;
  logic first_byte;
  logic second_byte;

  // Command decode, broadcast and direct forms alike
  assign is_enec  = command_code_i inside {CccEnecB, CccEnecD};
  assign is_disec = command_code_i inside {CccDisecB, CccDisecD};
  assign is_mwl   = command_code_i inside {CccSetmwlB, CccSetmwlD};
  assign is_mrl   = command_code_i inside {CccSetmrlB, CccSetmrlD};

  // Count still holds the byte index at the strobe
  assign first_byte  = data_done_strobe_i && (rx_count_i == 8'd0);
  assign second_byte = data_done_strobe_i && (rx_count_i == 8'd1);

  // Event flags from byte 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
    end else if (first_byte) begin
      if (is_enec) begin
        enec_ibi_o <= rx_byte_i[EnecIbiBit];
        enec_crr_o <= rx_byte_i[EnecCrrBit];
        enec_hj_o  <= rx_byte_i[EnecHjBit];
      end
      if (is_disec) begin
        disec_ibi_o <= rx_byte_i[EnecIbiBit];
        disec_crr_o <= rx_byte_i[EnecCrrBit];
        disec_hj_o  <= rx_byte_i[EnecHjBit];
      end
    end
  end

  // Lengths are big-endian, strobe on the low byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_o     <= '0;
      mrl_o     <= '0;
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
    end else begin
      set_mwl_o <= is_mwl && second_byte;
      set_mrl_o <= is_mrl && second_byte;
      if (is_mwl && first_byte) begin
        mwl_o[15:8] <= rx_byte_i;
      end
      if (is_mwl && second_byte) begin
        mwl_o[7:0] <= rx_byte_i;
      end
      if (is_mrl && first_byte) begin
        mrl_o[15:8] <= rx_byte_i;
      end
      if (is_mrl && second_byte) begin
        mrl_o[7:0] <= rx_byte_i;
      end
    end
  end

  // Shared dynamic address output
  // SETAASA copies static address, SETDASA takes byte 0 bits 7:1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_dasa_o       <= '0;
      set_dasa_valid_o <= 1'b0;
      rstdaa_o         <= 1'b0;
    end else begin
      set_dasa_valid_o <= 1'b0;
      rstdaa_o         <= bcast_tbit_strobe_i && (command_code_i == CccRstdaa);
      if (bcast_tbit_strobe_i && command_code_i == CccSetaasa) begin
        set_dasa_o       <= target_sta_address_i;
        set_dasa_valid_o <= 1'b1;
      end else if (first_byte && command_code_i == CccSetdasa) begin
        set_dasa_o       <= rx_byte_i[7:1];
        set_dasa_valid_o <= 1'b1;
      end
    end
  end

endmodule

//--- source/ccc_top.sv
// CCC handler top: sequencer, GET transmit and SET register blocks
`timescale 1ns/10ps

module ccc_top import ccc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Handoff from primary target FSM
  input  byte_t ccc_i,
  input  logic  ccc_valid_i,
  output logic  done_o,
  // Bus monitor
  input  logic  bus_rstart_det_i,
  input  logic  bus_stop_det_i,
  // Bus receiver
  input  logic  bus_rx_done_i,
  input  byte_t bus_rx_data_i,
  output logic  bus_rx_req_bit_o,
  output logic  bus_rx_req_byte_o,
  // Bus transmitter
  input  logic  bus_tx_done_i,
  output logic  bus_tx_req_bit_o,
  output logic  bus_tx_req_byte_o,
  output byte_t bus_tx_req_value_o,
  output logic  bus_tx_sel_od_pp_o,
  // Target addresses
  input  addr_t target_sta_address_i,
  input  logic  target_sta_address_valid_i,
  input  addr_t target_dyn_address_i,
  input  logic  target_dyn_address_valid_i,
  // GET sources
  input  byte_t get_bcr_i,
  input  byte_t get_dcr_i,
  input  len_t  get_mwl_i,
  input  len_t  get_mrl_i,
  input  pid_t  get_pid_i,
  input  len_t  get_status_fmt1_i,
  // SET results
  output logic  enec_ibi_o,
  output logic  enec_crr_o,
  output logic  enec_hj_o,
  output logic  disec_ibi_o,
  output logic  disec_crr_o,
  output logic  disec_hj_o,
  output logic  set_mwl_o,
  output len_t  mwl_o,
  output logic  set_mrl_o,
  output len_t  mrl_o,
  output addr_t set_dasa_o,
  output logic  set_dasa_valid_o,
  output logic  rstdaa_o
);

  byte_t command_code;
  byte_t rx_byte;
  byte_t rx_count;
  logic  data_done_strobe;
  logic  bcast_tbit_strobe;
  logic  tx_load;
  logic  tx_advance;
  byte_t tx_byte;
  logic  tx_last;

  ccc_seq_fsm u_ccc_seq_fsm (
    .clk_i, .rst_ni, .ccc_i, .ccc_valid_i, .bus_rstart_det_i, .bus_stop_det_i,
    .bus_rx_done_i, .bus_rx_data_i, .bus_tx_done_i,
    .target_sta_address_i, .target_sta_address_valid_i,
    .target_dyn_address_i, .target_dyn_address_valid_i,
    .tx_byte_i (tx_byte), .tx_last_i (tx_last),
    .done_o, .bus_rx_req_bit_o, .bus_rx_req_byte_o, .bus_tx_req_bit_o,
    .bus_tx_req_byte_o, .bus_tx_req_value_o, .bus_tx_sel_od_pp_o,
    .command_code_o (command_code), .rx_byte_o (rx_byte), .rx_count_o (rx_count),
    .data_done_strobe_o (data_done_strobe), .bcast_tbit_strobe_o (bcast_tbit_strobe),
    // Match already folded into the data strobe
    .addr_phase_ok_o (),
    .tx_load_o (tx_load), .tx_advance_o (tx_advance)
  );

  ccc_get_tx u_ccc_get_tx (
    .clk_i, .rst_ni, .command_code_i (command_code),
    .load_i (tx_load), .advance_i (tx_advance),
    .get_bcr_i, .get_dcr_i, .get_mwl_i, .get_mrl_i, .get_pid_i, .get_status_fmt1_i,
    .tx_byte_o (tx_byte), .tx_last_o (tx_last)
  );

  ccc_set_regs u_ccc_set_regs (
    .clk_i, .rst_ni, .command_code_i (command_code),
    .rx_byte_i (rx_byte), .rx_count_i (rx_count),
    .data_done_strobe_i (data_done_strobe), .bcast_tbit_strobe_i (bcast_tbit_strobe),
    .target_sta_address_i,
    .enec_ibi_o, .enec_crr_o, .enec_hj_o, .disec_ibi_o, .disec_crr_o, .disec_hj_o,
    .set_mwl_o, .mwl_o, .set_mrl_o, .mrl_o, .set_dasa_o, .set_dasa_valid_o, .rstdaa_o
  );

endmodule

//--- sim/ccc_chk.sv
// Bound assertions on CCC top-level bus requests, done pulse and length strobes
`timescale 1ns/10ps

module ccc_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic rx_req_bit_i,
  input logic rx_req_byte_i,
  input logic tx_req_bit_i,
  input logic tx_req_byte_i,
  input logic done_i,
  input logic set_mwl_i,
  input logic set_mrl_i
);

  // Read by the testbench at the end of the run
  int assert_fails = 0;

  // Bus is either receiving or driving, never both
  no_rx_tx_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_req_bit_i || rx_req_byte_i) && (tx_req_bit_i || tx_req_byte_i)))
    else begin
      assert_fails++;
      $error("receive and transmit requests high together");
    end

  // DoneCcc lasts one cycle
  done_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      assert_fails++;
      $error("done held longer than one cycle");
    end

  no_dual_len_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(set_mwl_i && set_mrl_i))
    else begin
      assert_fails++;
      $error("MWL and MRL strobes fired together");
    end

endmodule

bind ccc_top ccc_chk u_ccc_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .rx_req_bit_i  (bus_rx_req_bit_o),
  .rx_req_byte_i (bus_rx_req_byte_o),
  .tx_req_bit_i  (bus_tx_req_bit_o),
  .tx_req_byte_i (bus_tx_req_byte_o),
  .done_i        (done_o),
  .set_mwl_i     (set_mwl_o),
  .set_mrl_i     (set_mrl_o)
);

//--- sim/ccc_tb.sv
// CCC handler testbench: clock, bus stand-in, stimulus table, checks and timeout
`timescale 1ns/10ps

module ccc_tb import ccc_pkg::*; ();

  localparam int NumTests      = 12;
  localparam int TimeoutCycles = 400 * NumTests + 10;
  // Target configuration seen by the DUT
  localparam addr_t StaAddr  = 7'h35;
  localparam addr_t DynAddr  = 7'h52;
  localparam byte_t WrAddr   = {DynAddr, 1'b0};
  localparam byte_t RdAddr   = {DynAddr, 1'b1};
  localparam byte_t MissAddr = {7'h11, 1'b1};
  localparam byte_t Bcr      = 8'h66;
  localparam len_t  Mrl      = 16'h0A0B;
  localparam pid_t  Pid      = 48'h0123_4567_89AB;

  logic  clk_i, rst_ni, ccc_valid_i, done_o;
  byte_t ccc_i, bus_rx_data_i, bus_tx_req_value_o;
  logic  bus_rstart_det_i, bus_stop_det_i, bus_rx_done_i, bus_tx_done_i;
  logic  bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_byte_o;
  logic  bus_tx_sel_od_pp_o;
  addr_t target_sta_address_i, target_dyn_address_i, set_dasa_o;
  logic  target_sta_address_valid_i, target_dyn_address_valid_i;
  byte_t get_bcr_i, get_dcr_i;
  len_t  get_mwl_i, get_mrl_i, get_status_fmt1_i, mwl_o, mrl_o;
  pid_t  get_pid_i;
  logic  enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o, disec_hj_o;
  logic  set_mwl_o, set_mrl_o, set_dasa_valid_o, rstdaa_o;

  // Stimulus table, one entry per CCC
  string       t_name [NumTests];
  byte_t       t_code [NumTests];
  bit          t_direct [NumTests];
  byte_t       t_addr [NumTests];
  int          t_nbytes [NumTests];
  logic [47:0] t_data [NumTests];
  int          t_nget [NumTests];
  logic [47:0] t_exp [NumTests];
  bit          t_ack [NumTests];
  int          t_pulses [NumTests];
  int          n_tests = 0;

  // Per-test event counts
  int done_cnt = 0;
  int pulse_cnt = 0;
  int rstdaa_cnt = 0;
  int tx_req_cycles = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int cycle_cnt = 0;

  ccc_top u_ccc_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Outputs sampled mid-cycle
  always @(negedge clk_i) begin
    if (done_o) done_cnt++;
    if (set_mwl_o) pulse_cnt++;
    if (set_mrl_o) pulse_cnt++;
    if (set_dasa_valid_o) pulse_cnt++;
    if (rstdaa_o) begin
      pulse_cnt++;
      rstdaa_cnt++;
    end
    if (bus_tx_req_byte_o) tx_req_cycles++;
  end

  task automatic add_test(input string name, input byte_t code, input bit direct,
                          input byte_t addr, input int nbytes, input logic [47:0] data,
                          input int nget, input logic [47:0] exp, input bit ack,
                          input int pulses);
    t_name[n_tests]   = name;
    t_code[n_tests]   = code;
    t_direct[n_tests] = direct;
    t_addr[n_tests]   = addr;
    t_nbytes[n_tests] = nbytes;
    t_data[n_tests]   = data;
    t_nget[n_tests]   = nget;
    t_exp[n_tests]    = exp;
    t_ack[n_tests]    = ack;
    t_pulses[n_tests] = pulses;
    n_tests++;
  endtask

  // Bus side answers after 1 to 4 cycles
  task automatic wait_delay();
    repeat (1 + $urandom % 4) @(posedge clk_i);
  endtask

  task automatic answer_rx(input bit is_bit, input byte_t data);
    @(negedge clk_i);
    while (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o)) @(negedge clk_i);
    wait_delay();
    bus_rx_data_i <= data;
    bus_rx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
  endtask

  task automatic answer_tx(input bit is_bit, output byte_t value, output bit mode);
    @(negedge clk_i);
    while (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o)) @(negedge clk_i);
    value = bus_tx_req_value_o;
    mode  = bus_tx_sel_od_pp_o;
    wait_delay();
    bus_tx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic await_rx_byte(output bit seen);
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      @(negedge clk_i);
      seen = bus_rx_req_byte_o;
    end
  endtask

  task automatic send_rstart();
    @(posedge clk_i);
    bus_rstart_det_i <= 1'b1;
    @(posedge clk_i);
    bus_rstart_det_i <= 1'b0;
  endtask

  // STOP, then settle through DoneCcc and Idle back to WaitCcc
  task automatic send_stop();
    @(posedge clk_i);
    bus_stop_det_i <= 1'b1;
    @(posedge clk_i);
    bus_stop_det_i <= 1'b0;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic start_ccc(input byte_t code);
    @(posedge clk_i);
    ccc_i       <= code;
    ccc_valid_i <= 1'b1;
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
  endtask

  // Output that a SET code is expected to change
  function automatic logic [47:0] set_result(input byte_t code);
    logic [47:0] r;
    r = '0;
    case (code)
      CccEnecB, CccEnecD:     r[2:0] = {enec_ibi_o, enec_crr_o, enec_hj_o};
      CccDisecB, CccDisecD:   r[2:0] = {disec_ibi_o, disec_crr_o, disec_hj_o};
      CccSetmwlB, CccSetmwlD: r[15:0] = mwl_o;
      CccSetmrlB, CccSetmrlD: r[15:0] = mrl_o;
      CccSetaasa, CccSetdasa: r[6:0] = set_dasa_o;
      CccRstdaa:              r[31:0] = rstdaa_cnt;
      default:                r = '0;
    endcase
    return r;
  endfunction

  task automatic run_test(input int i);
    byte_t       ack;
    byte_t       val;
    byte_t       tbit;
    logic [47:0] stream;
    int          nsent;
    bit          exp_t;
    bit          seen;
    bit          ok;
    bit          mode;
    bit          tmode;
    ok = 1'b1;
    ack = '0;
    stream = '0;
    nsent = 0;
    done_cnt = 0;
    pulse_cnt = 0;
    rstdaa_cnt = 0;
    tx_req_cycles = 0;
    start_ccc(t_code[i]);
    answer_rx(1'b1, 8'h80);
    // Direct CCC: Sr, address byte, ACK bit
    if (t_direct[i]) begin
      await_rx_byte(seen);
      if (!seen) begin
        $display("%s: no byte request before the Repeated Start", t_name[i]);
        ok = 1'b0;
      end
      send_rstart();
      answer_rx(1'b0, t_addr[i]);
      answer_tx(1'b1, ack, mode);
      if (ack[0] !== t_ack[i]) begin
        $display("ERROR %s: ack expected %0h actual %0h", t_name[i], t_ack[i], ack[0]);
        ok = 1'b0;
      end
      // Address ACK is driven open drain
      if (mode !== 1'b0) begin
        $display("ERROR %s: ACK drive mode expected 0 actual %0h", t_name[i], mode);
        ok = 1'b0;
      end
    end
    if (ack[0]) begin
      // NACKed target sits out until the next Sr
      send_rstart();
      await_rx_byte(seen);
      if (!seen) begin
        $display("%s: no address receive after the Repeated Start", t_name[i]);
        ok = 1'b0;
      end
    end else if (t_direct[i] && t_addr[i][0]) begin
      tbit = 8'h01;
      while (tbit[0] && nsent < MaxGetBytes) begin
        answer_tx(1'b0, val, mode);
        stream = {stream[39:0], val};
        answer_tx(1'b1, tbit, tmode);
        exp_t = (nsent + 1 < t_nget[i]);
        if (tbit[0] !== exp_t) begin
          $display("ERROR %s: T-bit %0d expected %0h actual %0h", t_name[i], nsent, exp_t,
                   tbit[0]);
          ok = 1'b0;
        end
        // Read data and its T-bit go out push-pull
        if ({mode, tmode} !== 2'b11) begin
          $display("ERROR %s: read drive mode %0d expected 3 actual %0h", t_name[i], nsent,
                   {mode, tmode});
          ok = 1'b0;
        end
        nsent++;
      end
    end else begin
      for (int j = t_nbytes[i] - 1; j >= 0; j--) begin
        answer_rx(1'b0, t_data[i][8*j +: 8]);
        answer_rx(1'b1, 8'h00);
      end
      await_rx_byte(seen);
    end
    send_stop();
    if (done_cnt != 1) begin
      $display("ERROR %s: done pulses expected 1 actual %0d", t_name[i], done_cnt);
      ok = 1'b0;
    end
    if (pulse_cnt != t_pulses[i]) begin
      $display("ERROR %s: set strobes expected %0d actual %0d", t_name[i], t_pulses[i],
               pulse_cnt);
      ok = 1'b0;
    end
    if (ack[0] && tx_req_cycles != 0) begin
      $display("%s: transmit byte requested after a NACK", t_name[i]);
      ok = 1'b0;
    end else if (t_nget[i] != 0 && (nsent != t_nget[i] || stream !== t_exp[i])) begin
      $display("ERROR %s: GET bytes expected %0h actual %0h", t_name[i], t_exp[i], stream);
      ok = 1'b0;
    end else if (!ack[0] && t_nget[i] == 0 && set_result(t_code[i]) !== t_exp[i]) begin
      $display("ERROR %s: result expected %0h actual %0h", t_name[i], t_exp[i],
               set_result(t_code[i]));
      ok = 1'b0;
    end
    $display("%s %s", ok ? "PASS" : "FAIL", t_name[i]);
    if (ok) pass_cnt++;
    else fail_cnt++;
  endtask

  // Watchdog sized from the table length
  initial begin
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(60090));
    rst_ni = 1'b0;
    ccc_i = '0;
    ccc_valid_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_rx_data_i = '0;
    bus_tx_done_i = 1'b0;
    target_sta_address_i = StaAddr;
    target_sta_address_valid_i = 1'b1;
    target_dyn_address_i = DynAddr;
    target_dyn_address_valid_i = 1'b1;
    get_bcr_i = Bcr;
    get_dcr_i = 8'hC3;
    get_mwl_i = 16'h0100;
    get_mrl_i = Mrl;
    get_pid_i = Pid;
    get_status_fmt1_i = 16'h0000;
    // name, code, direct, addr, nbytes, data, nget, expected, ack, strobes
    add_test("enec_b", CccEnecB, 0, 8'h00, 1, 48'h0B, 0, 48'h7, 0, 0);
    add_test("disec_b", CccDisecB, 0, 8'h00, 1, 48'h01, 0, 48'h4, 0, 0);
    add_test("setmwl_b", CccSetmwlB, 0, 8'h00, 2, 48'h1234, 0, 48'h1234, 0, 1);
    add_test("setmrl_d", CccSetmrlD, 1, WrAddr, 2, 48'h5678, 0, 48'h5678, 0, 1);
    add_test("getpid", CccGetpid, 1, RdAddr, 0, 48'h0, 6, Pid, 0, 0);
    add_test("getmrl", CccGetmrl, 1, RdAddr, 0, 48'h0, 3, {Mrl, 8'hFF}, 0, 0);
    add_test("getbcr", CccGetbcr, 1, RdAddr, 0, 48'h0, 1, Bcr, 0, 0);
    add_test("get_miss", CccGetdcr, 1, MissAddr, 0, 48'h0, 0, 48'h0, 1, 0);
    add_test("setaasa", CccSetaasa, 0, 8'h00, 0, 48'h0, 0, StaAddr, 0, 1);
    add_test("setdasa", CccSetdasa, 1, WrAddr, 1, 48'h46, 0, 48'h23, 0, 1);
    add_test("rstdaa", CccRstdaa, 0, 8'h00, 0, 48'h0, 0, 48'h1, 0, 1);
    // STOP while the first MRL byte is pending, MRL keeps its old value
    add_test("stop_abort", CccSetmrlB, 0, 8'h00, 0, 48'h0, 0, 48'h5678, 0, 0);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d", n_tests, pass_cnt,
             fail_cnt, u_ccc_top.u_ccc_chk.assert_fails);
    if (fail_cnt == 0 && u_ccc_top.u_ccc_chk.assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sources.f
source/ccc_pkg.sv
source/ccc_seq_fsm.sv
source/ccc_get_tx.sv
source/ccc_set_regs.sv
source/ccc_top.sv
sim/ccc_chk.sv
sim/ccc_tb.sv
